// ==== tb/golden_vectors.txt ====
# W index addr data : one download write, all hex
# S|U joy1 joy2 mode rgb_in cycles port_a port_b port_c port_d hwsel pause rgb_out : S waits cycles, U polls up to cycles
# Idle after reset, then scramble layout with the fixed pattern 619
S 0 0 0 000000 1 ff ff ff ff 00 0 000000
S 619 0 0 123456 2 66 a7 ef ff 00 0 123456
# Game codes and their board codes
W 1 0 2
S 619 0 0 123456 2 66 a7 ef ff 01 0 123456
W 1 0 4
S 619 0 0 123456 2 69 ff bf ff 02 0 123456
W 1 0 8
S 619 0 0 123456 2 6a eb fe ff 03 0 123456
W 1 0 a
S 619 0 0 123456 2 6a a7 bf ff 06 0 123456
W 1 0 f
S 619 0 0 123456 2 66 a7 ef ff 0b 0 123456
W 1 0 d
S 619 0 0 123456 2 6a ab ef ff 0a 0 123456
W 1 0 12
S 619 0 0 123456 2 66 a7 ef ff 0c 0 123456
# Back to scramble, controls split over the two players
W 1 0 0
S 19 600 0 123456 2 66 a7 ef ff 00 0 123456
S 0 619 0 123456 2 66 a7 ef ff 00 0 123456
S 619 619 0 123456 2 66 a7 ef ff 00 0 123456
# DIP bytes mask the ports, address 8 is ignored
W fe 0 f0
W fe 1 0f
W fe 2 7f
W fe 3 aa
S 619 0 0 123456 2 60 07 6f aa 00 0 123456
W fe 8 00
S 619 0 0 123456 2 60 07 6f aa 00 0 123456
W fe 0 ff
W fe 1 ff
W fe 2 ff
W fe 3 ff
# Move and fire layouts on port_b
W 1 0 b
S a9 0 1 123456 2 eb eb ff ff 07 0 123456
S a9 0 0 123456 2 eb d7 ff ff 07 0 123456
S a9 0 1 123456 2 eb eb ff ff 07 0 123456
W 1 0 10
S a9 0 1 123456 2 eb eb ff ff 08 0 123456
S a9 0 0 123456 2 eb d7 ff ff 08 0 123456
# Pause, dim, release, unpause
W 1 0 0
U 800 0 0 80fe42 24 ff ff ff ff 00 1 407f21
S 0 0 0 80fe42 2 ff ff ff ff 00 1 407f21
U 800 0 0 80fe42 4 ff ff ff ff 00 0 80fe42
S 0 0 0 80fe42 2 ff ff ff ff 00 0 80fe42

// ==== tb.f ====
common/arcade_pkg.sv
hdl/cfg_loader.sv
input/joy_merge.sv
input/port_mapper.sv
hdl/pause_dim.sv
hdl/arcade_io_top.sv
tb/tb_arcade_io.sv

// ==== tb/tb_arcade_io.sv ====
// Testbench for the input and pause front end, replaying tb/golden_vectors.txt against the DUT
`timescale 1ns/1ps

module tb_arcade_io;
	import arcade_pkg::*;

	localparam int MAX_RECORDS = 1000;

	logic                 clk_sys;
	logic                 rst;
	logic                 dl_wr;
	logic [7:0]           dl_index;
	logic [DL_ADDR_W-1:0] dl_addr;
	logic [7:0]           dl_data;
	logic [JOY_W-1:0]     joy1;
	logic [JOY_W-1:0]     joy2;
	logic                 move_fire_mode;
	logic [RGB_W-1:0]     rgb_in;
	logic [PORT_W-1:0]    port_a;
	logic [PORT_W-1:0]    port_b;
	logic [PORT_W-1:0]    port_c;
	logic [PORT_W-1:0]    port_d;
	board_e               hwsel;
	logic                 pause;
	logic [RGB_W-1:0]     rgb_out;

	int            errors;
	int            checks;
	int            fd;
	int            code;
	int            records;
	int            f_cycles;
	logic          done;
	logic [63:0]   tag;
	logic [1023:0] rest;
	logic [31:0]   f [0:10];

	arcade_io_top #(
		.DIM_CYCLES(20)
	) arcade_io_top_i (
		.clk_sys, .rst, .dl_wr, .dl_index, .dl_addr, .dl_data,
		.joy1, .joy2, .move_fire_mode, .rgb_in,
		.port_a, .port_b, .port_c, .port_d, .hwsel, .pause, .rgb_out
	);

	initial
	begin
		clk_sys = 1'b0;
		forever
			#4 clk_sys = ~clk_sys;
	end

	// ==================================================
	// Helper tasks
	// ==================================================

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	// One byte on the download stream, held for a single cycle
	task automatic download_write(input logic [7:0] idx, input logic [31:0] addr,
		input logic [7:0] data);
		@(posedge clk_sys);
		dl_wr    <= 1'b1;
		dl_index <= idx;
		dl_addr  <= addr[DL_ADDR_W-1:0];
		dl_data  <= data;
		@(posedge clk_sys);
		dl_wr <= 1'b0;
	endtask

	// Drives the inputs, then either waits a fixed count or polls until the outputs match
	task automatic apply_and_check(input logic until_match, input int cycles);
		int   n;
		logic hit;
		@(posedge clk_sys);
		joy1           <= f[0];
		joy2           <= f[1];
		move_fire_mode <= f[2][0];
		rgb_in         <= f[3][RGB_W-1:0];
		n = 0;
		hit = 1'b0;
		while ((n < cycles) && !hit)
		begin
			@(posedge clk_sys);
			@(negedge clk_sys);
			n++;
			if (until_match)
				hit = (port_a === f[4][7:0]) && (port_b === f[5][7:0]) &&
					(port_c === f[6][7:0]) && (port_d === f[7][7:0]) &&
					(hwsel === f[8][7:0]) && (pause === f[9][0]) &&
					(rgb_out === f[10][RGB_W-1:0]);
		end
		if (until_match && !hit)
		begin
			errors++;
			$display("Timeout at %0t ns: outputs did not settle within %0d cycles", $time, cycles);
		end
		check_value("port_a", port_a, f[4]);
		check_value("port_b", port_b, f[5]);
		check_value("port_c", port_c, f[6]);
		check_value("port_d", port_d, f[7]);
		check_value("hwsel", hwsel, f[8]);
		check_value("pause", pause, f[9]);
		check_value("rgb_out", rgb_out, f[10]);
	endtask

	// ==================================================
	// Main sequence
	// ==================================================

	initial
	begin
		errors = 0;
		checks = 0;
		rst = 1'b1;
		dl_wr = 1'b0;
		dl_index = '0;
		dl_addr = '0;
		dl_data = '0;
		joy1 = '0;
		joy2 = '0;
		move_fire_mode = 1'b0;
		rgb_in = '0;
		for (int i = 0; i < 4; i++)
			@(posedge clk_sys);
		rst <= 1'b0;

		fd = $fopen("tb/golden_vectors.txt", "r");
		if (fd == 0)
		begin
			errors++;
			$display("Could not open the vector file tb/golden_vectors.txt");
		end
		else
		begin
			done = 1'b0;
			records = 0;
			while (!done)
			begin
				code = $fscanf(fd, "%s", tag);
				if (code != 1)
					done = 1'b1;
				else if (tag == "#")
					code = $fgets(rest, fd);
				else if (tag == "W")
				begin
					code = $fscanf(fd, "%h %h %h", f[0], f[1], f[2]);
					if (code == 3)
						download_write(f[0][7:0], f[1], f[2][7:0]);
					else
					begin
						errors++;
						$display("Download record %0d is incomplete", records);
						done = 1'b1;
					end
				end
				else if ((tag == "S") || (tag == "U"))
				begin
					code = $fscanf(fd, "%h %h %h %h %d %h %h %h %h %h %h %h", f[0], f[1], f[2],
						f[3], f_cycles, f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
					if (code == 12)
						apply_and_check(tag == "U", f_cycles);
					else
					begin
						errors++;
						$display("Check record %0d is incomplete", records);
						done = 1'b1;
					end
				end
				else
				begin
					errors++;
					$display("Unknown record type in the vector file");
					done = 1'b1;
				end
				records++;
				if (records >= MAX_RECORDS)
					done = 1'b1;
			end
			$fclose(fd);
		end

		if (checks == 0)
		begin
			errors++;
			$display("No output was checked");
		end
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// ==== hdl/arcade_io_top.sv ====
// Top level of the input and pause front end, connecting loader, input stages and pause stage
`timescale 1ns/1ps

module arcade_io_top #(
	parameter int unsigned DIM_CYCLES = arcade_pkg::DIM_CYCLES_DEFAULT
)
(
	input  logic                              clk_sys,
	input  logic                              rst,
	input  logic                              dl_wr,
	input  logic [7:0]                        dl_index,
	input  logic [arcade_pkg::DL_ADDR_W-1:0]  dl_addr,
	input  logic [7:0]                        dl_data,
	input  logic [arcade_pkg::JOY_W-1:0]      joy1,
	input  logic [arcade_pkg::JOY_W-1:0]      joy2,
	input  logic                              move_fire_mode,
	input  logic [arcade_pkg::RGB_W-1:0]      rgb_in,
	output logic [arcade_pkg::PORT_W-1:0]     port_a,
	output logic [arcade_pkg::PORT_W-1:0]     port_b,
	output logic [arcade_pkg::PORT_W-1:0]     port_c,
	output logic [arcade_pkg::PORT_W-1:0]     port_d,
	output arcade_pkg::board_e                hwsel,
	output logic                              pause,
	output logic [arcade_pkg::RGB_W-1:0]      rgb_out
);
	import arcade_pkg::*;

	game_e      game;
	logic [7:0] dip0, dip1, dip2, dip3;
	logic       up, down, left, right;
	logic       fire_a, fire_b, fire_c, fire_d, fire_e;
	logic       start1, start2, coin, pause_btn;

	cfg_loader cfg_loader_i (
		.clk_sys, .rst, .dl_wr, .dl_index, .dl_addr, .dl_data,
		.game, .dip0, .dip1, .dip2, .dip3
	);

	// Merge stage feeds the mapper and the pause button
	joy_merge joy_merge_i (
		.clk_sys, .rst, .joy1, .joy2,
		.up, .down, .left, .right,
		.fire_a, .fire_b, .fire_c, .fire_d, .fire_e,
		.start1, .start2, .coin, .pause_btn
	);

	port_mapper port_mapper_i (
		.clk_sys, .rst, .game, .dip0, .dip1, .dip2, .dip3, .move_fire_mode,
		.up, .down, .left, .right,
		.fire_a, .fire_b, .fire_c, .fire_d, .fire_e,
		.start1, .start2, .coin,
		.port_a, .port_b, .port_c, .port_d, .hwsel
	);

	pause_dim #(
		.DIM_CYCLES(DIM_CYCLES)
	) pause_dim_i (
		.clk_sys, .rst, .pause_btn, .rgb_in, .pause, .rgb_out
	);

endmodule

// ==== hdl/pause_dim.sv ====
// Pause toggle from the pause button, with a timer that dims the pixel stream after a long pause
`timescale 1ns/1ps

module pause_dim #(
	parameter int unsigned DIM_CYCLES = arcade_pkg::DIM_CYCLES_DEFAULT
)
(
	input  logic                          clk_sys,
	input  logic                          rst,
	input  logic                          pause_btn,
	input  logic [arcade_pkg::RGB_W-1:0]  rgb_in,
	output logic                          pause,
	output logic [arcade_pkg::RGB_W-1:0]  rgb_out
);
	import arcade_pkg::*;

	localparam int TMR_W = $clog2(DIM_CYCLES + 1);
	localparam logic [TMR_W-1:0] DIM_LIMIT = TMR_W'(DIM_CYCLES);

	logic             btn_q;
	logic             press_q;
	logic [TMR_W-1:0] timer;
	logic [RGB_W-1:0] rgb_half;

	// ==================================================
	// Button edge and pause toggle
	// ==================================================

	always_ff @(posedge clk_sys)
	begin
		if (rst)
		begin
			btn_q   <= 1'b0;
			press_q <= 1'b0;
			pause   <= 1'b0;
		end
		else
		begin
			btn_q   <= pause_btn;
			press_q <= pause_btn & ~btn_q;
			if (press_q)
				pause <= ~pause;
		end
	end

	// Dim timer saturates at the limit
	always_ff @(posedge clk_sys)
	begin
		if (rst || !pause)
			timer <= '0;
		else if (timer < DIM_LIMIT)
			timer <= timer + 1'b1;
	end

	// ==================================================
	// Pixel stage
	// ==================================================

	always_comb
	begin
		for (int i = 0; i < RGB_W / 8; i++)
			rgb_half[i*8 +: 8] = rgb_in[i*8 +: 8] >> 1;
	end

	always_ff @(posedge clk_sys)
	begin
		if (pause && (timer == DIM_LIMIT))
			rgb_out <= rgb_half;
		else
			rgb_out <= rgb_in;
	end

	a_timer_bounded : assert property (
		@(posedge clk_sys) disable iff (rst)
		timer <= DIM_LIMIT
	);

endmodule

// ==== input/port_mapper.sv ====
// Second input stage that maps merged controls onto the four active-low ports for the chosen game
`timescale 1ns/1ps

module port_mapper
(
	input  logic                           clk_sys,
	input  logic                           rst,
	input  arcade_pkg::game_e              game,
	input  logic [7:0]                     dip0,
	input  logic [7:0]                     dip1,
	input  logic [7:0]                     dip2,
	input  logic [7:0]                     dip3,
	input  logic                           move_fire_mode,
	input  logic                           up,
	input  logic                           down,
	input  logic                           left,
	input  logic                           right,
	input  logic                           fire_a,
	input  logic                           fire_b,
	input  logic                           fire_c,
	input  logic                           fire_d,
	input  logic                           fire_e,
	input  logic                           start1,
	input  logic                           start2,
	input  logic                           coin,
	output logic [arcade_pkg::PORT_W-1:0]  port_a,
	output logic [arcade_pkg::PORT_W-1:0]  port_b,
	output logic [arcade_pkg::PORT_W-1:0]  port_c,
	output logic [arcade_pkg::PORT_W-1:0]  port_d,
	output arcade_pkg::board_e             hwsel
);
	import arcade_pkg::*;

	logic [PORT_W-1:0] map_a;
	logic [PORT_W-1:0] map_b;
	logic [PORT_W-1:0] map_c;
	logic [PORT_W-1:0] map_d;
	board_e            map_hw;

	// ==================================================
	// Per-game bit layout
	// ==================================================

	always_comb
	begin
		// Scramble layout unless a game overrides it
		map_hw = hw_scramble;
		map_a  = ~{coin, 1'b0, left, right, fire_a, 1'b0, fire_b, up};
		map_b  = ~{start1, start2, left, right, fire_a, fire_b, 2'b00};
		map_c  = ~{1'b0, down, 1'b0, up, 3'b000, down};
		map_d  = 8'hFF;

		case (game)
			game_frogger:
				map_hw = hw_frogger;
			game_scobra, game_armorcar:
				map_hw = hw_scobra;
			game_tazman:
			begin
				map_hw = hw_scobra;
				map_a  = ~{coin, 1'b0, left, right, down, up, fire_a, fire_b};
				map_b  = 8'hFF;
				map_c  = ~{1'b0, start2, 5'b00000, start1};
			end
			game_spdcoin:
			begin
				map_hw = hw_scobra;
				map_a  = ~{coin, 1'b0, left, right, start2, 1'b0, start1, 1'b0};
				map_b  = 8'hFF;
				map_c  = 8'hFF;
			end
			game_calipso:
			begin
				// Fire doubles as the start buttons on this board
				map_hw = hw_calipso;
				map_a  = ~{coin, 1'b0, left, right, down, up, 1'b0, start2 | fire_a};
				map_b  = ~{2'b00, left, right, down, up, 2'b00};
				map_c  = ~{7'b0000000, fire_a | start1};
			end
			game_anteater:
			begin
				map_hw = hw_anteater;
				map_a  = ~{coin, 1'b0, left, right, down, up, 1'b0, fire_a};
				map_b  = ~{1'b0, fire_a, left, right, up, down, 2'b00};
				map_c  = ~{1'b0, start2, 5'b00000, start1};
			end
			game_losttomb:
			begin
				map_hw = hw_losttomb;
				map_a  = ~{coin, 1'b0, left, right, down, up, start1, start2};
				// Second stick either follows the move stick or the four fire buttons
				map_b  = move_fire_mode ?
					~{1'b0, fire_e | fire_a, left, right, down, up, 2'b00} :
					~{1'b0, fire_e, fire_d, fire_a, fire_b, fire_c, 2'b00};
				map_c  = 8'hFF;
			end
			game_mars:
			begin
				map_hw = hw_mars;
				if (move_fire_mode)
				begin
					map_a = ~{coin, 1'b0, left, right, left, right, 1'b0, up};
					map_b = ~{start1, start2, left, right, left, right, 2'b00};
					map_c = ~{up, down, down, up, 3'b000, down};
					map_d = ~{up, 1'b0, down, 5'b00000};
				end
				else
				begin
					map_a = ~{coin, 1'b0, left, right, fire_d, fire_a, 1'b0, up};
					map_b = ~{start1, start2, left, right, fire_d, fire_a, 2'b00};
					map_c = ~{fire_c, down, fire_b, up, 3'b000, down};
					map_d = ~{fire_c, 1'b0, fire_b, 5'b00000};
				end
			end
			game_stratgyx:
			begin
				map_hw = hw_stratgyx;
				map_c  = ~{fire_c, down, fire_c, up, 3'b000, down};
			end
			game_turtles:
			begin
				map_hw = hw_turtles;
				map_a  = ~{coin, 1'b0, left, right, fire_a, 2'b00, up};
				map_b  = ~{start1, start2, left, right, fire_a, 3'b000};
			end
			game_minefld, game_rescue:
			begin
				map_hw = (game == game_minefld) ? hw_minefld : hw_rescue;
				map_a  = ~{coin, 1'b0, left, right, down, up, 1'b0, start1};
				map_b  = move_fire_mode ?
					~{2'b00, left, right, down, up, 2'b00} :
					~{2'b00, fire_d, fire_a, fire_b, fire_c, 2'b00};
				map_c  = ~{1'b0, start2, 5'b00000, start1};
			end
			game_mimonkey:
				map_hw = hw_mimonkey;
			default:
				map_hw = hw_scramble;
		endcase
	end

	// ==================================================
	// DIP masking and output register
	// ==================================================

	always_ff @(posedge clk_sys)
	begin
		if (rst)
		begin
			port_a <= 8'hFF;
			port_b <= 8'hFF;
			port_c <= 8'hFF;
			port_d <= 8'hFF;
			hwsel  <= hw_scramble;
		end
		else
		begin
			port_a <= dip0 & map_a;
			port_b <= dip1 & map_b;
			port_c <= dip2 & map_c;
			port_d <= dip3 & map_d;
			hwsel  <= map_hw;
		end
	end

	// Game code from the loader must always resolve to a board
	a_hwsel_known : assert property (
		@(posedge clk_sys) disable iff (rst)
		!$isunknown(hwsel)
	);

endmodule

// ==== input/joy_merge.sv ====
// First input stage that registers both joysticks merged into one set of controls
`timescale 1ns/1ps

module joy_merge
(
	input  logic                          clk_sys,
	input  logic                          rst,
	input  logic [arcade_pkg::JOY_W-1:0]  joy1,
	input  logic [arcade_pkg::JOY_W-1:0]  joy2,
	output logic                          up,
	output logic                          down,
	output logic                          left,
	output logic                          right,
	output logic                          fire_a,
	output logic                          fire_b,
	output logic                          fire_c,
	output logic                          fire_d,
	output logic                          fire_e,
	output logic                          start1,
	output logic                          start2,
	output logic                          coin,
	output logic                          pause_btn
);
	import arcade_pkg::*;

	// Either player drives every control
	logic [JOY_W-1:0] joy_all;

	assign joy_all = joy1 | joy2;

	always_ff @(posedge clk_sys)
	begin
		if (rst)
		begin
			{up, down, left, right} <= '0;
			{fire_a, fire_b, fire_c, fire_d, fire_e} <= '0;
			{start1, start2, coin, pause_btn} <= '0;
		end
		else
		begin
			up     <= joy_all[JOY_UP];
			down   <= joy_all[JOY_DOWN];
			left   <= joy_all[JOY_LEFT];
			right  <= joy_all[JOY_RIGHT];
			fire_a <= joy_all[JOY_FIRE_A];
			fire_b <= joy_all[JOY_FIRE_B];
			fire_c <= joy_all[JOY_FIRE_C];
			fire_d <= joy_all[JOY_FIRE_D];
			fire_e <= joy_all[JOY_FIRE_E];
			// System buttons
			start1    <= joy_all[JOY_START1];
			start2    <= joy_all[JOY_START2];
			coin      <= joy_all[JOY_COIN];
			pause_btn <= joy_all[JOY_PAUSE];
		end
	end

endmodule

// ==== hdl/cfg_loader.sv ====
// Captures the game select byte and the DIP switch bytes from the download stream
`timescale 1ns/1ps

module cfg_loader
(
	input  logic                              clk_sys,
	input  logic                              rst,
	input  logic                              dl_wr,
	input  logic [7:0]                        dl_index,
	input  logic [arcade_pkg::DL_ADDR_W-1:0]  dl_addr,
	input  logic [7:0]                        dl_data,
	output arcade_pkg::game_e                 game,
	output logic [7:0]                        dip0,
	output logic [7:0]                        dip1,
	output logic [7:0]                        dip2,
	output logic [7:0]                        dip3
);
	import arcade_pkg::*;

	logic [7:0] dip_q [NUM_DIPS];
	logic       game_wr;
	logic       dip_wr;

	// DIP writes only land in the first four addresses
	assign game_wr = dl_wr && (dl_index == DL_IDX_GAME);
	assign dip_wr = dl_wr && (dl_index == DL_IDX_DIP) && (dl_addr[DL_ADDR_W-1:2] == '0);

	always_ff @(posedge clk_sys)
	begin
		if (rst)
		begin
			game <= game_scramble;
			for (int i = 0; i < NUM_DIPS; i++)
				dip_q[i] <= 8'hFF;
		end
		else
		begin
			if (game_wr)
				game <= game_e'(dl_data);
			if (dip_wr)
				dip_q[dl_addr[1:0]] <= dl_data;
		end
	end

	assign dip0 = dip_q[0];
	assign dip1 = dip_q[1];
	assign dip2 = dip_q[2];
	assign dip3 = dip_q[3];

	// Host must only select games this board supports
	a_game_code_kept : assert property (
		@(posedge clk_sys) disable iff (rst)
		game_wr |-> dl_data inside {game_scramble, game_frogger, game_scobra,
			game_tazman, game_armorcar, game_spdcoin, game_calipso, game_anteater,
			game_losttomb, game_mars, game_stratgyx, game_turtles, game_minefld,
			game_rescue, game_mimonkey}
	);

endmodule

// ==== common/arcade_pkg.sv ====
// Shared game codes, board codes, download indices and joystick bit positions for the input front end
package arcade_pkg;

	// ==================================================
	// Game and board codes
	// ==================================================

	// Game select byte as written by the download stream at index 1
	typedef enum logic [7:0]
	{
		game_scramble = 8'd0,
		game_frogger  = 8'd2,
		game_scobra   = 8'd3,
		game_tazman   = 8'd4,
		game_armorcar = 8'd5,
		game_spdcoin  = 8'd7,
		game_calipso  = 8'd8,
		game_anteater = 8'd10,
		game_losttomb = 8'd11,
		game_mars     = 8'd13,
		game_stratgyx = 8'd14,
		game_turtles  = 8'd15,
		game_minefld  = 8'd16,
		game_rescue   = 8'd17,
		game_mimonkey = 8'd18
	} game_e;

	// Hardware select code seen by the game core
	// Code 4 belonged to a spinner board and is unused here
	typedef enum logic [7:0]
	{
		hw_scramble = 8'd0,
		hw_frogger  = 8'd1,
		hw_scobra   = 8'd2,
		hw_calipso  = 8'd3,
		hw_stratgyx = 8'd5,
		hw_anteater = 8'd6,
		hw_losttomb = 8'd7,
		hw_minefld  = 8'd8,
		hw_rescue   = 8'd9,
		hw_mars     = 8'd10,
		hw_turtles  = 8'd11,
		hw_mimonkey = 8'd12
	} board_e;

	// ==================================================
	// Download stream
	// ==================================================

	localparam int DL_ADDR_W = 25;
	localparam logic [7:0] DL_IDX_GAME = 8'd1;
	localparam logic [7:0] DL_IDX_DIP = 8'd254;
	localparam int NUM_DIPS = 4;

	// ==================================================
	// Joystick word layout
	// ==================================================

	localparam int JOY_W = 32;

	localparam int JOY_RIGHT  = 0;
	localparam int JOY_LEFT   = 1;
	localparam int JOY_DOWN   = 2;
	localparam int JOY_UP     = 3;
	localparam int JOY_FIRE_A = 4;
	localparam int JOY_FIRE_B = 5;
	localparam int JOY_FIRE_C = 6;
	localparam int JOY_FIRE_D = 7;
	localparam int JOY_FIRE_E = 8;
	// Start 1 shares bit 8 with fire E, as on the host side
	localparam int JOY_START1 = 8;
	localparam int JOY_START2 = 9;
	localparam int JOY_COIN   = 10;
	localparam int JOY_PAUSE  = 11;

	// Port and pixel widths
	localparam int PORT_W = 8;
	localparam int RGB_W = 24;

	// About ten seconds at the board clock before the paused picture dims
	localparam int unsigned DIM_CYCLES_DEFAULT = 240_000_000;

endpackage
